// File: hdl/ioPredicate_defines.svh
// --------------------
// I/O predication unit parameters
// Address width, port count and the fixed read and write port windows
// --------------------

`ifndef IO_PREDICATE_DEFINES_SVH
`define IO_PREDICATE_DEFINES_SVH

// Data memory address width in bits, shared by the read and write addresses
`define IO_ADDR_WIDTH 10

// Number of read ports, and equally of write ports
`define IO_PORT_COUNT 4

// --------------------
// Port windows

// Read port p answers at IO_READ_BASE + p
`define IO_READ_BASE 10'h3F0

// Write port p answers at IO_WRITE_BASE + p
// The two windows do not overlap so that one address never means both
`define IO_WRITE_BASE 10'h3F8

`endif

// File: hdl/ioPredicatePkg.sv
// --------------------
// I/O predication types
// Port selections, per-port stage-2 checks and the annulled enables
// --------------------

`include "ioPredicate_defines.svh"

package ioPredicatePkg;

    // --------------------
    // Stage 1 result

    // One-hot or zero per direction
    // Bit p of readSelect means the instruction reads port p
    // Bit p of writeSelect means the instruction writes port p
    typedef struct packed {
        logic [`IO_PORT_COUNT-1:0] readSelect;
        logic [`IO_PORT_COUNT-1:0] writeSelect;
    } portSelect;

    // --------------------
    // Stage 2 result, one per port

    // The selected bits carry the decode forward to the enables
    // A blocked bit is set when the port is selected but not ready
    typedef struct packed {
        logic readSelected;
        logic writeSelected;
        logic readBlocked;
        logic writeBlocked;
    } portCheck;

    // --------------------
    // Final output

    // Read enable pops a read port and write enable pushes a write port
    // Both are zero for an annulled instruction
    typedef struct packed {
        logic [`IO_PORT_COUNT-1:0] readEnable;
        logic [`IO_PORT_COUNT-1:0] writeEnable;
    } portEnables;

endpackage

// File: hdl/ioAddressDecoder.sv
// --------------------
// I/O address decoder, stage 1
// Maps the read and write addresses onto registered one-hot port selects
// --------------------

`include "ioPredicate_defines.svh"

module ioAddressDecoder (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`IO_ADDR_WIDTH-1:0]     readAddr,
    input  logic [`IO_ADDR_WIDTH-1:0]     writeAddr,
    output ioPredicatePkg::portSelect     selection
);

    // --------------------
    // Window decode

    // Turns an address into a one-hot select for the window starting at base
    // The subtraction is unsigned, so an address below base wraps to a large
    // offset and falls out of the window just like one above it
    function automatic logic [`IO_PORT_COUNT-1:0] windowSelect(
        input logic [`IO_ADDR_WIDTH-1:0] addr,
        input logic [`IO_ADDR_WIDTH-1:0] base
    );
        logic [`IO_ADDR_WIDTH-1:0] offset;
        logic                      inWindow;
        logic [`IO_PORT_COUNT-1:0] oneHot;
        offset   = addr - base;
        inWindow = (offset < `IO_ADDR_WIDTH'(`IO_PORT_COUNT));
        oneHot   = '0;
        // Only the port whose number equals the offset is selected
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            oneHot[p] = inWindow && (offset == `IO_ADDR_WIDTH'(p));
        end
        return oneHot;
    endfunction

    // Next selection, before the stage 1 register
    ioPredicatePkg::portSelect nextSelection;

    always_comb begin
        // Reads only look at the read window and writes only at the write window
        nextSelection.readSelect  = windowSelect(readAddr, `IO_READ_BASE);
        nextSelection.writeSelect = windowSelect(writeAddr, `IO_WRITE_BASE);
    end

    // --------------------
    // Stage 1 register

    // Addresses held before edge k give the selection from edge k on
    // Out-of-window addresses register as all zeros and so touch no port
    always_ff @(posedge clock) begin
        if (reset) begin
            selection <= '0;
        end else begin
            selection <= nextSelection;
        end
    end

endmodule

// File: hdl/ioPortCheck.sv
// --------------------
// Per-port readiness check, stage 2
// Registers the select bits together with their blocked state
// --------------------

`include "ioPredicate_defines.svh"

module ioPortCheck (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       readSelect,
    input  logic                       writeSelect,
    input  logic                       readFull,
    input  logic                       writeFull,
    output ioPredicatePkg::portCheck   check
);

    // --------------------
    // Readiness masks

    // A read port is ready when it holds data, so a selected read is
    // blocked while its flag is still empty
    logic readBlockedNext;

    // A write port is ready when it has room, so a selected write is
    // blocked while its flag shows full
    logic writeBlockedNext;

    // Unselected ports never block, whatever their flags say
    assign readBlockedNext  = readSelect & ~readFull;
    assign writeBlockedNext = writeSelect & writeFull;

    // --------------------
    // Stage 2 register

    // The flags are sampled on the same edge as the stage 1 selection,
    // which is one edge after the addresses were taken
    always_ff @(posedge clock) begin
        if (reset) begin
            check <= '0;
        end else begin
            // Keep the raw selects so the combiner can build the enables
            check.readSelected  <= readSelect;
            check.writeSelected <= writeSelect;
            check.readBlocked   <= readBlockedNext;
            check.writeBlocked  <= writeBlockedNext;
        end
    end

endmodule

// File: hdl/ioReadyCombiner.sv
// --------------------
// Ready combiner and enable annulment
// Reduces all port checks to one ready level and gates the enables with it
// --------------------

`include "ioPredicate_defines.svh"

module ioReadyCombiner (
    input  ioPredicatePkg::portCheck [`IO_PORT_COUNT-1:0] checks,
    output logic                                          ioReady,
    output ioPredicatePkg::portEnables                    enables
);

    // --------------------
    // Gather

    // Any selected port that is not ready marks the whole instruction
    logic                      notReady;

    // Selected ports in each direction, collected from the port checks
    logic [`IO_PORT_COUNT-1:0] readSelected;
    logic [`IO_PORT_COUNT-1:0] writeSelected;

    always_comb begin
        notReady      = 1'b0;
        readSelected  = '0;
        writeSelected = '0;
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            // A blocked read and a blocked write both annul the instruction
            notReady         = notReady | checks[p].readBlocked | checks[p].writeBlocked;
            readSelected[p]  = checks[p].readSelected;
            writeSelected[p] = checks[p].writeSelected;
        end
    end

    // --------------------
    // Ready and annulment

    // An instruction that touches no port has nothing blocked and so is ready
    assign ioReady = ~notReady;

    // Only let the enables through when every accessed port is ready
    // Otherwise a read would pop data that the annulled instruction never
    // consumes, or a write would push data that is about to be discarded
    // Both vectors are annulled together even if only one side was blocked
    always_comb begin
        enables.readEnable  = readSelected & {`IO_PORT_COUNT{ioReady}};
        enables.writeEnable = writeSelected & {`IO_PORT_COUNT{ioReady}};
    end

endmodule

// File: hdl/ioPredicator.sv
// --------------------
// I/O predication unit, top level
// Address decode, per-port flag checks and the ready combiner
// --------------------

`include "ioPredicate_defines.svh"

module ioPredicator (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`IO_ADDR_WIDTH-1:0]         readAddr,
    input  logic [`IO_ADDR_WIDTH-1:0]         writeAddr,
    input  logic [`IO_PORT_COUNT-1:0]         readFull,
    input  logic [`IO_PORT_COUNT-1:0]         writeFull,
    output logic                              ioReady,
    output ioPredicatePkg::portEnables        enables
);

    // Stage 1 result, one-hot per direction
    ioPredicatePkg::portSelect                    selection;

    // Stage 2 result, one entry per port
    ioPredicatePkg::portCheck [`IO_PORT_COUNT-1:0] checks;

    // --------------------
    // Stage 1

    ioAddressDecoder decoderInst (
        .clock     (clock),
        .reset     (reset),
        .readAddr  (readAddr),
        .writeAddr (writeAddr),
        .selection (selection)
    );

    // --------------------
    // Stage 2

    // Port p pairs read port p with write port p, each with its own flag
    for (genvar p = 0; p < `IO_PORT_COUNT; p++) begin : portCheckGen
        ioPortCheck portCheckInst (
            .clock       (clock),
            .reset       (reset),
            .readSelect  (selection.readSelect[p]),
            .writeSelect (selection.writeSelect[p]),
            .readFull    (readFull[p]),
            .writeFull   (writeFull[p]),
            .check       (checks[p])
        );
    end

    // --------------------
    // Ready and enables

    // Combinational on the stage 2 registers, two edges after the addresses
    ioReadyCombiner combinerInst (
        .checks  (checks),
        .ioReady (ioReady),
        .enables (enables)
    );

endmodule

// File: sim/ioPredicator_props.sv
// --------------------
// Properties of the I/O predication unit
// Enable shape, ready gating and the quiet first cycle after reset
// --------------------

`include "ioPredicate_defines.svh"

module ioPredicator_props (
    input logic                       clock,
    input logic                       reset,
    input logic                       ioReady,
    input ioPredicatePkg::portEnables enables
);

    timeunit 1ns;
    timeprecision 1ns;

    // Number of assertion failures so far
    int failCount = 0;

    // --------------------
    // Enable shape

    // One instruction reads at most one port
    readOneHot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(enables.readEnable))
        else begin
            failCount++;
            $error("read enable selects more than one port");
        end

    // One instruction writes at most one port
    writeOneHot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(enables.writeEnable))
        else begin
            failCount++;
            $error("write enable selects more than one port");
        end

    // --------------------
    // Annulment

    // An annulled instruction must not touch any port
    enableNeedsReady: assert property (@(posedge clock) disable iff (reset)
        ((|enables.readEnable) || (|enables.writeEnable)) |-> ioReady)
        else begin
            failCount++;
            $error("port enabled while ioReady is low");
        end

    // Stage 2 was cleared by reset, so the first result is an empty one
    quietAfterReset: assert property (@(posedge clock)
        $fell(reset) |-> (enables == '0) && ioReady)
        else begin
            failCount++;
            $error("enables or ioReady wrong in the cycle after reset");
        end

endmodule

// File: sim/ioPredicatorTb.sv
// --------------------
// Testbench for the I/O predication unit
// Directed and random instructions checked against a reference model
// --------------------

`include "ioPredicate_defines.svh"

module ioPredicatorTb;

    timeunit 1ns;
    timeprecision 1ns;

    // --------------------
    // Run length and timing

    localparam int clockPeriod = 100;
    localparam int resetCycles = 8;
    localparam int portCount   = `IO_PORT_COUNT;

    // Instructions issued over the whole run
    localparam int testCycles = 2000;

    // Ten percent over the run leaves room for reset and the pipeline drain
    localparam int timeoutCycles = testCycles + testCycles / 10;

    localparam logic [`IO_ADDR_WIDTH-1:0] readBase  = `IO_READ_BASE;
    localparam logic [`IO_ADDR_WIDTH-1:0] writeBase = `IO_WRITE_BASE;

    // What the DUT should show for one instruction
    typedef struct packed {
        logic                       ready;
        ioPredicatePkg::portEnables enables;
    } expectedResult;

    logic                          clock;
    logic                          reset;
    logic [`IO_ADDR_WIDTH-1:0]     readAddr;
    logic [`IO_ADDR_WIDTH-1:0]     writeAddr;
    logic [`IO_PORT_COUNT-1:0]     readFull;
    logic [`IO_PORT_COUNT-1:0]     writeFull;
    logic                          ioReady;
    ioPredicatePkg::portEnables    enables;

    // Inputs of the last four cycles, indexed by the low bits of driveCount
    // Two instructions are in flight, so four slots are more than enough
    logic [`IO_ADDR_WIDTH-1:0] histReadAddr [4];
    logic [`IO_ADDR_WIDTH-1:0] histWriteAddr [4];
    logic [`IO_PORT_COUNT-1:0] histReadFull [4];
    logic [`IO_PORT_COUNT-1:0] histWriteFull [4];

    int driveCount   = 0;
    int cycleCount   = 0;
    int checkCount   = 0;
    int readyErrors  = 0;
    int enableErrors = 0;

    ioPredicator dut_i (
        .clock     (clock),
        .reset     (reset),
        .readAddr  (readAddr),
        .writeAddr (writeAddr),
        .readFull  (readFull),
        .writeFull (writeFull),
        .ioReady   (ioReady),
        .enables   (enables)
    );

    // Assertions ride along on the only ioPredicator instance
    bind ioPredicator ioPredicator_props propsInst (
        .clock   (clock),
        .reset   (reset),
        .ioReady (ioReady),
        .enables (enables)
    );

    initial begin : clockGen
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // --------------------
    // Reference model

    // Expected result for one instruction from its addresses and the flags
    // seen at its stage 2 edge, one cycle after the addresses
    function automatic expectedResult referenceResult(
        input logic [`IO_ADDR_WIDTH-1:0] rAddr,
        input logic [`IO_ADDR_WIDTH-1:0] wAddr,
        input logic [`IO_PORT_COUNT-1:0] rFull,
        input logic [`IO_PORT_COUNT-1:0] wFull
    );
        expectedResult             result;
        logic [`IO_PORT_COUNT-1:0] readSel;
        logic [`IO_PORT_COUNT-1:0] writeSel;
        logic                      blocked;
        readSel  = '0;
        writeSel = '0;
        // Port p answers exactly at base + p in its own window
        for (int p = 0; p < portCount; p++) begin
            if (int'(rAddr) == int'(readBase) + p) begin
                readSel = readSel | (`IO_PORT_COUNT'(1) << p);
            end
            if (int'(wAddr) == int'(writeBase) + p) begin
                writeSel = writeSel | (`IO_PORT_COUNT'(1) << p);
            end
        end
        // Reads need a full port and writes need an empty one
        blocked = (|(readSel & ~rFull)) || (|(writeSel & wFull));
        result.ready               = !blocked;
        result.enables.readEnable  = result.ready ? readSel : '0;
        result.enables.writeEnable = result.ready ? writeSel : '0;
        return result;
    endfunction

    // --------------------
    // Stimulus helpers

    function automatic logic inWindow(
        input logic [`IO_ADDR_WIDTH-1:0] addr,
        input logic [`IO_ADDR_WIDTH-1:0] base
    );
        return (int'(addr) >= int'(base)) && (int'(addr) < int'(base) + portCount);
    endfunction

    // Random address that misses both windows
    function automatic logic [`IO_ADDR_WIDTH-1:0] outsideAddr();
        logic [`IO_ADDR_WIDTH-1:0] addr;
        addr = `IO_ADDR_WIDTH'($urandom);
        while (inWindow(addr, readBase) || inWindow(addr, writeBase)) begin
            addr = `IO_ADDR_WIDTH'($urandom);
        end
        return addr;
    endfunction

    // Half the draws land inside the window, the rest anywhere or on its edges
    function automatic logic [`IO_ADDR_WIDTH-1:0] randomAddr(
        input logic [`IO_ADDR_WIDTH-1:0] base
    );
        logic [`IO_ADDR_WIDTH-1:0] addr;
        case ($urandom % 4)
            0, 1: addr = `IO_ADDR_WIDTH'(int'(base) + int'($urandom % portCount));
            2: addr = `IO_ADDR_WIDTH'($urandom);
            default: begin
                if ($urandom % 2 == 0) begin
                    addr = `IO_ADDR_WIDTH'(int'(base) - 1);
                end else begin
                    addr = `IO_ADDR_WIDTH'(int'(base) + portCount);
                end
            end
        endcase
        return addr;
    endfunction

    // Corner n of a window: base - 1, base, last port, one past the last port
    function automatic logic [`IO_ADDR_WIDTH-1:0] cornerAddr(
        input logic [`IO_ADDR_WIDTH-1:0] base,
        input int                        n
    );
        int offset;
        case (n)
            0: offset = -1;
            1: offset = 0;
            2: offset = portCount - 1;
            default: offset = portCount;
        endcase
        return `IO_ADDR_WIDTH'(int'(base) + offset);
    endfunction

    function automatic logic [`IO_PORT_COUNT-1:0] randomFlags();
        return `IO_PORT_COUNT'($urandom);
    endfunction

    function automatic logic [`IO_PORT_COUNT-1:0] portBit(input int p);
        return `IO_PORT_COUNT'(1) << p;
    endfunction

    // Drives one cycle of inputs at the falling edge and logs them
    task automatic driveCycle(
        input logic [`IO_ADDR_WIDTH-1:0] rAddr,
        input logic [`IO_ADDR_WIDTH-1:0] wAddr,
        input logic [`IO_PORT_COUNT-1:0] rFull,
        input logic [`IO_PORT_COUNT-1:0] wFull
    );
        readAddr  = rAddr;
        writeAddr = wAddr;
        readFull  = rFull;
        writeFull = wFull;
        histReadAddr[2'(driveCount)]  = rAddr;
        histWriteAddr[2'(driveCount)] = wAddr;
        histReadFull[2'(driveCount)]  = rFull;
        histWriteFull[2'(driveCount)] = wFull;
        driveCount++;
        @(negedge clock);
    endtask

    // The flags that an instruction sees go out one cycle after its addresses
    task automatic issueDirected(
        input logic [`IO_ADDR_WIDTH-1:0] rAddr,
        input logic [`IO_ADDR_WIDTH-1:0] wAddr,
        input logic [`IO_PORT_COUNT-1:0] rFull,
        input logic [`IO_PORT_COUNT-1:0] wFull
    );
        driveCycle(rAddr, wAddr, randomFlags(), randomFlags());
        driveCycle(outsideAddr(), outsideAddr(), rFull, wFull);
    endtask

    // --------------------
    // Checking

    task automatic checkResult(input string what, input expectedResult expected);
        checkCount++;
        if (ioReady !== expected.ready) begin
            readyErrors++;
            $display("ERR %0t ns: %s ioReady %b, expected %b",
                $time, what, ioReady, expected.ready);
        end
        if (enables !== expected.enables) begin
            enableErrors++;
            $display("ERR %0t ns: %s enables %b, expected %b",
                $time, what, enables, expected.enables);
        end
    endtask

    initial begin : compareOutputs
        expectedResult expected;
        int            instruction;
        logic [1:0]    addrSlot;
        logic [1:0]    flagSlot;
        forever begin
            @(posedge clock);
            // Outputs come from registers, so they hold until the next edge
            #(clockPeriod / 4);
            if (driveCount == 1) begin
                // First edge out of reset still shows the cleared stage 2
                expected = '0;
                expected.ready = 1'b1;
                checkResult("first cycle after reset", expected);
            end else if (driveCount >= 2) begin
                instruction = driveCount - 2;
                addrSlot    = 2'(instruction);
                flagSlot    = 2'(instruction + 1);
                expected = referenceResult(histReadAddr[addrSlot], histWriteAddr[addrSlot],
                    histReadFull[flagSlot], histWriteFull[flagSlot]);
                checkResult($sformatf("instruction %0d", instruction), expected);
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
        $display("Regression failed");
        $finish;
    end

    // --------------------
    // Main sequence

    initial begin : mainSequence
        logic [`IO_ADDR_WIDTH-1:0] base;
        logic [`IO_ADDR_WIDTH-1:0] corner;
        logic [`IO_ADDR_WIDTH-1:0] rAddr;
        logic [`IO_ADDR_WIDTH-1:0] wAddr;
        void'($urandom(32'hfd32378f));
        reset     = 1'b1;
        readAddr  = '0;
        writeAddr = '0;
        readFull  = '0;
        writeFull = '0;
        repeat (resetCycles) @(negedge clock);
        reset = 1'b0;

        // Window corners, once with every port ready and once with random flags
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? readBase : writeBase;
            for (int n = 0; n < 4; n++) begin
                corner = cornerAddr(base, n);
                issueDirected(corner, corner, '1, '0);
                issueDirected(corner, corner, randomFlags(), randomFlags());
            end
        end

        // Every read and write port pair, both ready and then blocked three ways
        for (int p = 0; p < portCount; p++) begin
            for (int q = 0; q < portCount; q++) begin
                rAddr = `IO_ADDR_WIDTH'(int'(readBase) + p);
                wAddr = `IO_ADDR_WIDTH'(int'(writeBase) + q);
                issueDirected(rAddr, wAddr, randomFlags() | portBit(p),
                    randomFlags() & ~portBit(q));
                issueDirected(rAddr, wAddr, randomFlags() & ~portBit(p),
                    randomFlags() & ~portBit(q));
                issueDirected(rAddr, wAddr, randomFlags() | portBit(p),
                    randomFlags() | portBit(q));
                issueDirected(rAddr, wAddr, randomFlags() & ~portBit(p),
                    randomFlags() | portBit(q));
            end
        end

        // Addresses that miss both windows never depend on the flags
        repeat (200) begin
            driveCycle(outsideAddr(), outsideAddr(), randomFlags(), randomFlags());
        end

        // Back-to-back random traffic with new flags on every cycle
        while (driveCount < testCycles) begin
            driveCycle(randomAddr(readBase), randomAddr(writeBase),
                randomFlags(), randomFlags());
        end

        // Push the last real instruction through both stages
        repeat (2) driveCycle(outsideAddr(), outsideAddr(), '0, '0);

        $display("Checks %0d, ioReady errors %0d, enable errors %0d, assertion failures %0d",
            checkCount, readyErrors, enableErrors, dut_i.propsInst.failCount);
        if (readyErrors == 0 && enableErrors == 0 && dut_i.propsInst.failCount == 0
                && checkCount > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/ioPredicatePkg.sv
hdl/ioAddressDecoder.sv
hdl/ioPortCheck.sv
hdl/ioReadyCombiner.sv
hdl/ioPredicator.sv
sim/ioPredicator_props.sv
sim/ioPredicatorTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the I/O predication unit testbench with Verilator.
# The run passes only when the log holds the pass line of the testbench.

set -u

cd "$(dirname "$0")" || exit 1

TOP=ioPredicatorTb
BUILD_DIR=obj_dir
LOG=sim.log

echo "Compiling $TOP"
verilator --binary --timing --assert \
    -f tb.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Compile failed with status $status"
    exit 1
fi

echo "Running $TOP"
"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
